//--- wg_settings.svh
// Size and timing defaults for the write-channel guard.
// Included by the package and by every RTL file that sizes its logic.

`ifndef WG_SETTINGS_SVH
`define WG_SETTINGS_SVH

// Number of outstanding writes tracked at once
`define WG_NUM_SLOTS 4

// Transaction ID width on AW and B
`define WG_ID_WIDTH 4

// Write address width
`define WG_ADDR_WIDTH 32

// Width of phase tick counts and of the budgets they are compared with
`define WG_CNT_WIDTH 8

// Clocks per prescaled tick
`define WG_PRESCALE_DIV 4

`endif

//--- wg_pkg.sv
// Shared types for the write-channel guard.
// RTL files refer to these by scoped name, sized from the settings header.

`default_nettype none

`include "wg_settings.svh"

package wg_pkg;

  // Slot index width, kept at one bit for a single-slot table
  localparam int unsigned IdxWidth = (`WG_NUM_SLOTS > 1) ? $clog2(`WG_NUM_SLOTS) : 1;

  typedef logic [IdxWidth-1:0]         slot_idx_t;
  typedef logic [`WG_ID_WIDTH-1:0]     txn_id_t;
  typedef logic [`WG_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`WG_CNT_WIDTH-1:0]    tick_cnt_t;

  // Lifecycle of one tracked write
  typedef enum logic [1:0] {
    PH_FREE = 2'd0,
    PH_ADDR = 2'd1,
    PH_DATA = 2'd2,
    PH_RESP = 2'd3
  } phase_e;

  // Reason reported with the interrupt
  typedef enum logic [2:0] {
    CAUSE_NONE       = 3'd0,
    CAUSE_AW_TIMEOUT = 3'd1,
    CAUSE_W_TIMEOUT  = 3'd2,
    CAUSE_B_TIMEOUT  = 3'd3,
    CAUSE_UNWANTED_B = 3'd4
  } cause_e;

endpackage

`default_nettype wire

//--- wg_prescaler.sv
// Tick generator for the phase counters.
// Pulses tick_o for one clock every WG_PRESCALE_DIV clocks.

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_prescaler (
  input  logic clk_i,
  input  logic rst_ni,
  output logic tick_o
);

  localparam int unsigned Div      = `WG_PRESCALE_DIV;
  localparam int unsigned DivWidth = (Div > 1) ? $clog2(Div) : 1;

  logic [DivWidth-1:0] div_cnt_q;

  // Down-counter, reload on wrap and emit the tick
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_cnt_q <= '0;
      tick_o    <= 1'b0;
    end else if (div_cnt_q == '0) begin
      div_cnt_q <= DivWidth'(Div - 1);
      tick_o    <= 1'b1;
    end else begin
      div_cnt_q <= div_cnt_q - 1'b1;
      tick_o    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- wg_order_queue.sv
// Circular queue of slot indices in address-accept order.
// The head entry is the slot that owns the next W burst.
// Flushed together with the table on an abort.

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_order_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              push_i,
  input  wg_pkg::slot_idx_t push_idx_i,
  input  logic              pop_i,
  output wg_pkg::slot_idx_t head_idx_o,
  output logic              nonempty_o
);

  localparam int unsigned Depth    = `WG_NUM_SLOTS;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  wg_pkg::slot_idx_t   mem_q [Depth];
  wg_pkg::slot_idx_t   wr_ptr_q;
  wg_pkg::slot_idx_t   rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  // Wraps at Depth, which need not be a power of two
  function automatic wg_pkg::slot_idx_t ptr_next(input wg_pkg::slot_idx_t ptr);
    if (ptr == wg_pkg::slot_idx_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

  assign head_idx_o = mem_q[rd_ptr_q];
  assign nonempty_o = (count_q != '0);

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q != CntWidth'(Depth)));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> nonempty_o);

endmodule

`default_nettype wire

//--- wg_age_match.sv
// Picks the slot that a B response belongs to.
// An older-than matrix keeps allocation order, so the oldest
// response-phase slot with the B ID wins.

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_age_match (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  logic                                alloc_i,
  input  wg_pkg::slot_idx_t                   alloc_idx_i,
  input  logic            [`WG_NUM_SLOTS-1:0] resp_ready_i,
  input  wg_pkg::txn_id_t [`WG_NUM_SLOTS-1:0] slot_id_i,
  input  logic                                b_fire_i,
  input  wg_pkg::txn_id_t                     b_id_i,
  output logic                                hit_o,
  output wg_pkg::slot_idx_t                   hit_idx_o,
  output logic                                unwanted_o
);

  localparam int unsigned N = `WG_NUM_SLOTS;

  // older_q[i][j] set means slot j was allocated before slot i
  logic [N-1:0][N-1:0] older_q;
  logic [N-1:0]        cand;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      older_q <= '0;
    end else if (flush_i) begin
      older_q <= '0;
    end else if (alloc_i) begin
      // New slot is younger than all others and older than none
      for (int j = 0; j < N; j++) begin
        older_q[alloc_idx_i][j] <= (wg_pkg::slot_idx_t'(j) != alloc_idx_i);
        older_q[j][alloc_idx_i] <= 1'b0;
      end
    end
  end

  for (genvar g = 0; g < N; g++) begin : gen_cand
    assign cand[g] = resp_ready_i[g] && (slot_id_i[g] == b_id_i);
  end

  // Only one candidate has no older candidate
  always_comb begin
    hit_idx_o = '0;
    for (int i = 0; i < N; i++) begin
      if (cand[i] && !(|(older_q[i] & cand))) begin
        hit_idx_o = wg_pkg::slot_idx_t'(i);
      end
    end
  end

  assign hit_o      = b_fire_i && (|cand);
  assign unwanted_o = b_fire_i && !(|cand);

  a_hit_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit_o |-> (resp_ready_i[hit_idx_o] && (slot_id_i[hit_idx_o] == b_id_i)));

endmodule

`default_nettype wire

//--- wg_txn_table.sv
// Transaction table of the write guard.
// Tracks each write through address, data and response phases,
// counts prescaled ticks per phase and aborts everything on a
// budget overrun or an unexpected B response.

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_txn_table (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              aw_valid_i,
  input  logic              aw_ready_i,
  input  wg_pkg::txn_id_t   aw_id_i,
  input  wg_pkg::addr_t     aw_addr_i,
  input  logic              w_valid_i,
  input  logic              w_ready_i,
  input  logic              w_last_i,
  input  logic              b_valid_i,
  input  logic              b_ready_i,
  input  wg_pkg::txn_id_t   b_id_i,
  input  wg_pkg::tick_cnt_t budget_aw_i,
  input  wg_pkg::tick_cnt_t budget_w_i,
  input  wg_pkg::tick_cnt_t budget_b_i,
  output logic              busy_o,
  output logic              full_o,
  output logic              abort_o,
  output wg_pkg::cause_e    abort_cause_o,
  output wg_pkg::txn_id_t   abort_id_o,
  output wg_pkg::addr_t     abort_addr_o
);

  localparam int unsigned N = `WG_NUM_SLOTS;

  wg_pkg::phase_e    [N-1:0] phase_q;
  wg_pkg::tick_cnt_t [N-1:0] cnt_q;
  wg_pkg::txn_id_t   [N-1:0] id_q;
  wg_pkg::addr_t     [N-1:0] addr_q;

  logic              tick;
  logic              aw_fire;
  logic              w_last_fire;
  logic              b_fire;
  logic              aw_seen_q;
  logic [N-1:0]      occupied;
  logic [N-1:0]      resp_ready;
  logic [N-1:0]      timeout;
  logic              alloc;
  wg_pkg::slot_idx_t alloc_idx;
  logic              addr_busy;
  wg_pkg::slot_idx_t addr_idx;
  logic              to_any;
  wg_pkg::slot_idx_t to_idx;
  logic              push;
  wg_pkg::slot_idx_t push_idx;
  logic              pop;
  wg_pkg::slot_idx_t head_idx;
  logic              q_nonempty;
  logic              hit;
  wg_pkg::slot_idx_t hit_idx;
  logic              unwanted;

  assign aw_fire     = aw_valid_i && aw_ready_i;
  assign w_last_fire = w_valid_i && w_ready_i && w_last_i;
  assign b_fire      = b_valid_i && b_ready_i;

  // Current AW request already seen whether tracked or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_seen_q <= 1'b0;
    end else begin
      aw_seen_q <= aw_valid_i && !aw_ready_i;
    end
  end

  for (genvar g = 0; g < N; g++) begin : gen_slot_status
    assign occupied[g]   = (phase_q[g] != wg_pkg::PH_FREE);
    assign resp_ready[g] = (phase_q[g] == wg_pkg::PH_RESP);
  end

  // Budget of the phase each slot is in
  always_comb begin
    timeout = '0;
    for (int i = 0; i < N; i++) begin
      case (phase_q[i])
        wg_pkg::PH_ADDR: timeout[i] = (cnt_q[i] > budget_aw_i);
        wg_pkg::PH_DATA: timeout[i] = (cnt_q[i] > budget_w_i);
        wg_pkg::PH_RESP: timeout[i] = (cnt_q[i] > budget_b_i);
        default:         timeout[i] = 1'b0;
      endcase
    end
  end

  // Scan downwards so the lowest index wins; at most one slot is in PH_ADDR
  always_comb begin
    alloc_idx = '0;
    addr_busy = 1'b0;
    addr_idx  = '0;
    to_any    = 1'b0;
    to_idx    = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        alloc_idx = wg_pkg::slot_idx_t'(i);
      end
      if (phase_q[i] == wg_pkg::PH_ADDR) begin
        addr_busy = 1'b1;
        addr_idx  = wg_pkg::slot_idx_t'(i);
      end
      if (timeout[i]) begin
        to_any = 1'b1;
        to_idx = wg_pkg::slot_idx_t'(i);
      end
    end
  end

  assign busy_o = |occupied;
  assign full_o = &occupied;

  // Requests that start while full are left untracked
  assign alloc    = aw_valid_i && !aw_seen_q && !full_o && !abort_o;
  assign push     = aw_fire && (alloc || addr_busy) && !abort_o;
  assign push_idx = alloc ? alloc_idx : addr_idx;
  assign pop      = w_last_fire && q_nonempty && !abort_o;

  always_comb begin
    abort_o       = to_any || unwanted;
    abort_cause_o = wg_pkg::CAUSE_NONE;
    abort_id_o    = b_id_i;
    abort_addr_o  = '0;
    if (to_any) begin
      abort_id_o   = id_q[to_idx];
      abort_addr_o = addr_q[to_idx];
      case (phase_q[to_idx])
        wg_pkg::PH_ADDR: abort_cause_o = wg_pkg::CAUSE_AW_TIMEOUT;
        wg_pkg::PH_DATA: abort_cause_o = wg_pkg::CAUSE_W_TIMEOUT;
        default:         abort_cause_o = wg_pkg::CAUSE_B_TIMEOUT;
      endcase
    end else if (unwanted) begin
      abort_cause_o = wg_pkg::CAUSE_UNWANTED_B;
    end
  end

  // Phase machine and tick counters
  // The count restarts on every phase change
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N; i++) begin
        phase_q[i] <= wg_pkg::PH_FREE;
        cnt_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        if (abort_o) begin
          phase_q[i] <= wg_pkg::PH_FREE;
          cnt_q[i]   <= '0;
        end else if (alloc && (alloc_idx == wg_pkg::slot_idx_t'(i))) begin
          phase_q[i] <= aw_fire ? wg_pkg::PH_DATA : wg_pkg::PH_ADDR;
          cnt_q[i]   <= '0;
        end else if (aw_fire && (phase_q[i] == wg_pkg::PH_ADDR)) begin
          phase_q[i] <= wg_pkg::PH_DATA;
          cnt_q[i]   <= '0;
        end else if (pop && (head_idx == wg_pkg::slot_idx_t'(i))) begin
          phase_q[i] <= wg_pkg::PH_RESP;
          cnt_q[i]   <= '0;
        end else if (hit && (hit_idx == wg_pkg::slot_idx_t'(i))) begin
          phase_q[i] <= wg_pkg::PH_FREE;
          cnt_q[i]   <= '0;
        end else if (tick && occupied[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N; i++) begin
      if (alloc && (alloc_idx == wg_pkg::slot_idx_t'(i))) begin
        id_q[i]   <= aw_id_i;
        addr_q[i] <= aw_addr_i;
      end
    end
  end

  wg_prescaler i_prescaler (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tick_o (tick)
  );

  wg_order_queue i_order_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (abort_o),
    .push_i     (push),
    .push_idx_i (push_idx),
    .pop_i      (pop),
    .head_idx_o (head_idx),
    .nonempty_o (q_nonempty)
  );

  wg_age_match i_age_match (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (abort_o),
    .alloc_i      (alloc),
    .alloc_idx_i  (alloc_idx),
    .resp_ready_i (resp_ready),
    .slot_id_i    (id_q),
    .b_fire_i     (b_fire),
    .b_id_i       (b_id_i),
    .hit_o        (hit),
    .hit_idx_o    (hit_idx),
    .unwanted_o   (unwanted)
  );

  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc |-> (phase_q[alloc_idx] == wg_pkg::PH_FREE));

endmodule

`default_nettype wire

//--- write_guard.sv
// Top level of the write-channel guard.
// Monitors one AW/W/B link without stalling it and raises a sticky
// interrupt and reset request on a timeout or unexpected response.
// reset_clear_i drops both and releases the captured cause.

`timescale 1ns/1ps
`default_nettype none

module write_guard (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              aw_valid_i,
  input  logic              aw_ready_i,
  input  wg_pkg::txn_id_t   aw_id_i,
  input  wg_pkg::addr_t     aw_addr_i,
  input  logic              w_valid_i,
  input  logic              w_ready_i,
  input  logic              w_last_i,
  input  logic              b_valid_i,
  input  logic              b_ready_i,
  input  wg_pkg::txn_id_t   b_id_i,
  input  wg_pkg::tick_cnt_t budget_aw_i,
  input  wg_pkg::tick_cnt_t budget_w_i,
  input  wg_pkg::tick_cnt_t budget_b_i,
  input  logic              reset_clear_i,
  output logic              reset_req_o,
  output logic              irq_o,
  output wg_pkg::cause_e    irq_cause_o,
  output wg_pkg::txn_id_t   irq_id_o,
  output wg_pkg::addr_t     irq_addr_o,
  output logic              busy_o,
  output logic              full_o
);

  logic            abort;
  wg_pkg::cause_e  abort_cause;
  wg_pkg::txn_id_t abort_id;
  wg_pkg::addr_t   abort_addr;
  logic            latched_q;
  logic            capture;

  wg_txn_table i_txn_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_i    (aw_ready_i),
    .aw_id_i       (aw_id_i),
    .aw_addr_i     (aw_addr_i),
    .w_valid_i     (w_valid_i),
    .w_ready_i     (w_ready_i),
    .w_last_i      (w_last_i),
    .b_valid_i     (b_valid_i),
    .b_ready_i     (b_ready_i),
    .b_id_i        (b_id_i),
    .budget_aw_i   (budget_aw_i),
    .budget_w_i    (budget_w_i),
    .budget_b_i    (budget_b_i),
    .busy_o        (busy_o),
    .full_o        (full_o),
    .abort_o       (abort),
    .abort_cause_o (abort_cause),
    .abort_id_o    (abort_id),
    .abort_addr_o  (abort_addr)
  );

  // First abort wins until cleared; a clear in the same cycle lets a new one in
  assign capture = abort && (!latched_q || reset_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latched_q   <= 1'b0;
      irq_cause_o <= wg_pkg::CAUSE_NONE;
    end else if (capture) begin
      latched_q   <= 1'b1;
      irq_cause_o <= abort_cause;
    end else if (reset_clear_i) begin
      latched_q   <= 1'b0;
      irq_cause_o <= wg_pkg::CAUSE_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      irq_id_o   <= abort_id;
      irq_addr_o <= abort_addr;
    end
  end

  assign reset_req_o = latched_q;
  assign irq_o       = latched_q;

endmodule

`default_nettype wire

//--- tb_write_guard.sv
// Testbench for the write-channel guard.
// Drives AW/W/B traffic on the falling clock edge and checks the guard's
// outputs with concurrent assertions sampled on the rising edge.

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module tb_write_guard;

  localparam int Seed        = 14;
  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 3;
  localparam int Div         = `WG_PRESCALE_DIV;
  localparam int NumSlots    = `WG_NUM_SLOTS;
  localparam int BudgetAw    = 4;
  localparam int BudgetW     = 6;
  localparam int BudgetB     = 12;
  localparam int MaxDelay    = 4;

  // Worst-case report latency per phase from the phase start
  localparam int AwWindow = (BudgetAw + 2) * Div + 2;
  localparam int WWindow  = (BudgetW + 2) * Div + 2;
  localparam int BWindow  = (BudgetB + 2) * Div + 2;

  // Upper bounds on the length of each test in cycles
  localparam int NormalLen   = 3 * (2 * MaxDelay + 12) + 20;
  localparam int TimeoutLen  = AwWindow + WWindow + BWindow + 3 * 30;
  localparam int UnwantedLen = 40;
  localparam int CapacityLen = NumSlots * 8 + 40;
  localparam int MaxCycles   = ResetCycles + NormalLen + TimeoutLen + UnwantedLen
                               + CapacityLen + 100;

  logic              clk_i;
  logic              rst_ni;
  logic              aw_valid_i;
  logic              aw_ready_i;
  wg_pkg::txn_id_t   aw_id_i;
  wg_pkg::addr_t     aw_addr_i;
  logic              w_valid_i;
  logic              w_ready_i;
  logic              w_last_i;
  logic              b_valid_i;
  logic              b_ready_i;
  wg_pkg::txn_id_t   b_id_i;
  wg_pkg::tick_cnt_t budget_aw_i;
  wg_pkg::tick_cnt_t budget_w_i;
  wg_pkg::tick_cnt_t budget_b_i;
  logic              reset_clear_i;
  logic              reset_req_o;
  logic              irq_o;
  wg_pkg::cause_e    irq_cause_o;
  wg_pkg::txn_id_t   irq_id_o;
  wg_pkg::addr_t     irq_addr_o;
  logic              busy_o;
  logic              full_o;

  // Check strobes and expected values set by the stimulus
  string           test_name;
  logic            quiet_en;
  logic            chk_irq;
  logic            chk_busy;
  logic            chk_full;
  logic            chk_cause;
  logic            chk_id;
  logic            chk_addr;
  logic            exp_irq;
  logic            exp_busy;
  logic            exp_full;
  wg_pkg::cause_e  exp_cause;
  wg_pkg::txn_id_t exp_id;
  wg_pkg::addr_t   exp_addr;
  int              errors;
  int              checks;
  int              cycles;

  write_guard dut_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_i    (aw_ready_i),
    .aw_id_i       (aw_id_i),
    .aw_addr_i     (aw_addr_i),
    .w_valid_i     (w_valid_i),
    .w_ready_i     (w_ready_i),
    .w_last_i      (w_last_i),
    .b_valid_i     (b_valid_i),
    .b_ready_i     (b_ready_i),
    .b_id_i        (b_id_i),
    .budget_aw_i   (budget_aw_i),
    .budget_w_i    (budget_w_i),
    .budget_b_i    (budget_b_i),
    .reset_clear_i (reset_clear_i),
    .reset_req_o   (reset_req_o),
    .irq_o         (irq_o),
    .irq_cause_o   (irq_cause_o),
    .irq_id_o      (irq_id_o),
    .irq_addr_o    (irq_addr_o),
    .busy_o        (busy_o),
    .full_o        (full_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  a_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    quiet_en |-> !(irq_o || reset_req_o))
    else begin
      errors++;
      $display("error %s: irq/reset_req expected 0/0 actual %b/%b", test_name,
               $sampled(irq_o), $sampled(reset_req_o));
    end

  a_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_irq |-> (irq_o == exp_irq) && (reset_req_o == exp_irq))
    else begin
      errors++;
      $display("error %s: irq/reset_req expected %b/%b actual %b/%b", test_name,
               $sampled(exp_irq), $sampled(exp_irq), $sampled(irq_o),
               $sampled(reset_req_o));
    end

  a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_busy |-> (busy_o == exp_busy))
    else begin
      errors++;
      $display("error %s: busy expected %b actual %b", test_name,
               $sampled(exp_busy), $sampled(busy_o));
    end

  a_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_full |-> (full_o == exp_full))
    else begin
      errors++;
      $display("error %s: full expected %b actual %b", test_name,
               $sampled(exp_full), $sampled(full_o));
    end

  a_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_cause |-> (irq_cause_o == exp_cause))
    else begin
      errors++;
      $display("error %s: cause expected %0d actual %0d", test_name,
               $sampled(exp_cause), $sampled(irq_cause_o));
    end

  a_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_id |-> (irq_id_o == exp_id))
    else begin
      errors++;
      $display("error %s: id expected %0h actual %0h", test_name,
               $sampled(exp_id), $sampled(irq_id_o));
    end

  a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_addr |-> (irq_addr_o == exp_addr))
    else begin
      errors++;
      $display("error %s: addr expected %0h actual %0h", test_name,
               $sampled(exp_addr), $sampled(irq_addr_o));
    end

  // Word-aligned random address
  function automatic wg_pkg::addr_t rand_addr();
    return wg_pkg::addr_t'($urandom()) & ~wg_pkg::addr_t'(3);
  endfunction

  // Bus tasks start and end on a falling edge
  task automatic send_aw(input wg_pkg::txn_id_t id, input wg_pkg::addr_t addr,
                         input int ready_delay);
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_valid_i = 1'b1;
    aw_ready_i = 1'b0;
    repeat (ready_delay) @(negedge clk_i);
    aw_ready_i = 1'b1;
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    aw_ready_i = 1'b0;
  endtask

  task automatic send_w(input int delay, input int beats);
    repeat (delay) @(negedge clk_i);
    for (int i = 0; i < beats; i++) begin
      w_valid_i = 1'b1;
      w_ready_i = 1'b1;
      w_last_i  = (i == beats - 1);
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    w_ready_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  task automatic send_b(input wg_pkg::txn_id_t id, input int delay);
    repeat (delay) @(negedge clk_i);
    b_id_i    = id;
    b_valid_i = 1'b1;
    b_ready_i = 1'b1;
    @(negedge clk_i);
    b_valid_i = 1'b0;
    b_ready_i = 1'b0;
  endtask

  // Waits at most window cycles for the interrupt to rise
  task automatic wait_irq(input int window);
    int n;
    n = 0;
    while (!irq_o && (n < window)) begin
      @(negedge clk_i);
      n++;
    end
  endtask

  task automatic check_status(input logic irq, input logic busy);
    exp_irq  = irq;
    exp_busy = busy;
    chk_irq  = 1'b1;
    chk_busy = 1'b1;
    checks += 2;
    @(negedge clk_i);
    chk_irq  = 1'b0;
    chk_busy = 1'b0;
  endtask

  task automatic check_full(input logic full);
    exp_full = full;
    chk_full = 1'b1;
    checks++;
    @(negedge clk_i);
    chk_full = 1'b0;
  endtask

  task automatic check_cause(input wg_pkg::cause_e cause);
    exp_cause = cause;
    chk_cause = 1'b1;
    checks++;
    @(negedge clk_i);
    chk_cause = 1'b0;
  endtask

  task automatic check_id(input wg_pkg::txn_id_t id);
    exp_id = id;
    chk_id = 1'b1;
    checks++;
    @(negedge clk_i);
    chk_id = 1'b0;
  endtask

  task automatic check_addr(input wg_pkg::addr_t addr);
    exp_addr = addr;
    chk_addr = 1'b1;
    checks++;
    @(negedge clk_i);
    chk_addr = 1'b0;
  endtask

  // Outputs stay high in the clear cycle and drop on the next one
  task automatic clear_irq();
    reset_clear_i = 1'b1;
    exp_irq       = 1'b1;
    chk_irq       = 1'b1;
    @(negedge clk_i);
    reset_clear_i = 1'b0;
    exp_irq       = 1'b0;
    @(negedge clk_i);
    chk_irq = 1'b0;
    checks += 2;
  endtask

  task automatic normal_writes();
    wg_pkg::txn_id_t id_a;
    wg_pkg::txn_id_t id_b;
    test_name = "normal_writes";
    id_a      = wg_pkg::txn_id_t'($urandom());
    id_b      = id_a ^ wg_pkg::txn_id_t'(1);
    quiet_en  = 1'b1;
    send_aw(id_a, rand_addr(), $urandom_range(MaxDelay));
    send_w($urandom_range(2), $urandom_range(3, 1));
    send_aw(id_b, rand_addr(), $urandom_range(MaxDelay));
    send_w($urandom_range(2), $urandom_range(3, 1));
    send_aw(id_a, rand_addr(), $urandom_range(MaxDelay));
    send_w($urandom_range(2), $urandom_range(3, 1));
    // Second ID answers first
    send_b(id_b, $urandom_range(3));
    check_status(1'b0, 1'b1);
    send_b(id_a, $urandom_range(3));
    check_status(1'b0, 1'b1);
    send_b(id_a, $urandom_range(3));
    check_status(1'b0, 1'b0);
    quiet_en = 1'b0;
  endtask

  task automatic aw_timeout();
    wg_pkg::txn_id_t id;
    wg_pkg::addr_t   addr;
    test_name  = "aw_timeout";
    id         = wg_pkg::txn_id_t'($urandom());
    addr       = rand_addr();
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_valid_i = 1'b1;
    aw_ready_i = 1'b0;
    wait_irq(AwWindow + 1);
    check_status(1'b1, 1'b0);
    check_cause(wg_pkg::CAUSE_AW_TIMEOUT);
    check_id(id);
    check_addr(addr);
    aw_valid_i = 1'b0;
    clear_irq();
  endtask

  task automatic w_timeout();
    wg_pkg::txn_id_t id;
    wg_pkg::addr_t   addr;
    test_name = "w_timeout";
    id        = wg_pkg::txn_id_t'($urandom());
    addr      = rand_addr();
    send_aw(id, addr, $urandom_range(MaxDelay));
    wait_irq(WWindow + 1);
    check_status(1'b1, 1'b0);
    check_cause(wg_pkg::CAUSE_W_TIMEOUT);
    check_id(id);
    check_addr(addr);
    // Sticky until cleared
    repeat (2) check_status(1'b1, 1'b0);
    clear_irq();
  endtask

  task automatic b_timeout();
    wg_pkg::txn_id_t id;
    wg_pkg::addr_t   addr;
    test_name = "b_timeout";
    id        = wg_pkg::txn_id_t'($urandom());
    addr      = rand_addr();
    send_aw(id, addr, $urandom_range(MaxDelay));
    send_w($urandom_range(2), $urandom_range(3, 1));
    wait_irq(BWindow + 1);
    check_status(1'b1, 1'b0);
    check_cause(wg_pkg::CAUSE_B_TIMEOUT);
    check_id(id);
    check_addr(addr);
    clear_irq();
  endtask

  task automatic unwanted_b();
    wg_pkg::txn_id_t id;
    wg_pkg::txn_id_t stray_id;
    test_name = "unwanted_b";
    id        = wg_pkg::txn_id_t'($urandom());
    stray_id  = id ^ wg_pkg::txn_id_t'(5);
    send_aw(id, rand_addr(), 0);
    send_w(0, 1);
    send_b(stray_id, $urandom_range(3));
    check_status(1'b1, 1'b0);
    check_cause(wg_pkg::CAUSE_UNWANTED_B);
    check_id(stray_id);
    clear_irq();
  endtask

  task automatic capacity_order();
    wg_pkg::txn_id_t rep;
    test_name = "capacity_order";
    rep       = wg_pkg::txn_id_t'($urandom());
    quiet_en  = 1'b1;
    // Slots 0 and 2 share an ID
    for (int k = 0; k < NumSlots; k++) begin
      send_aw((k == 2) ? rep : rep ^ wg_pkg::txn_id_t'(k), rand_addr(), 0);
      send_w(0, 1);
    end
    check_full(1'b1);
    check_status(1'b0, 1'b1);
    // Started while full and left untracked
    send_aw(rep ^ wg_pkg::txn_id_t'(NumSlots), rand_addr(), 0);
    check_status(1'b0, 1'b1);
    check_full(1'b1);
    for (int k = 1; k < NumSlots; k++) begin
      if (k != 2) begin
        send_b(rep ^ wg_pkg::txn_id_t'(k), 0);
        check_full(1'b0);
        check_status(1'b0, 1'b1);
      end
    end
    send_b(rep, 0);
    check_status(1'b0, 1'b1);
    send_b(rep, 0);
    check_status(1'b0, 1'b0);
    quiet_en = 1'b0;
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MaxCycles);
    $display("checks %0d errors %0d", checks, errors);
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(Seed));
    rst_ni        = 1'b0;
    aw_valid_i    = 1'b0;
    aw_ready_i    = 1'b0;
    aw_id_i       = '0;
    aw_addr_i     = '0;
    w_valid_i     = 1'b0;
    w_ready_i     = 1'b0;
    w_last_i      = 1'b0;
    b_valid_i     = 1'b0;
    b_ready_i     = 1'b0;
    b_id_i        = '0;
    budget_aw_i   = wg_pkg::tick_cnt_t'(BudgetAw);
    budget_w_i    = wg_pkg::tick_cnt_t'(BudgetW);
    budget_b_i    = wg_pkg::tick_cnt_t'(BudgetB);
    reset_clear_i = 1'b0;
    quiet_en      = 1'b0;
    chk_irq       = 1'b0;
    chk_busy      = 1'b0;
    chk_full      = 1'b0;
    chk_cause     = 1'b0;
    chk_id        = 1'b0;
    chk_addr      = 1'b0;
    errors        = 0;
    checks        = 0;
    test_name     = "reset";
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;

    check_status(1'b0, 1'b0);
    check_full(1'b0);
    check_cause(wg_pkg::CAUSE_NONE);
    normal_writes();
    aw_timeout();
    w_timeout();
    b_timeout();
    unwanted_b();
    capacity_order();

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
wg_pkg.sv
wg_prescaler.sv
wg_order_queue.sv
wg_age_match.sv
wg_txn_table.sv
write_guard.sv
tb_write_guard.sv

//--- Makefile
# Verilator flow for the write-channel guard
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_write_guard
RTL_TOP   ?= write_guard
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= sim failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# A crash or a logged failure both fail the target
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
